/* Bender.yml */
package:
  name: particle_draw

sources:
  - hdl/particle_pkg.sv
  - hdl/draw_fsm.sv
  - hdl/frame_timer.sv
  - hdl/particle_state.sv
  - hdl/pixel_writer.sv
  - hdl/particle_draw_top.sv
  - target: test
    files:
      - verif/particle_draw_props.sv
      - verif/particle_draw_tb.sv

/* hdl/draw_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module draw_fsm (
	input  wire  CLOCK_50,
	input  wire  reset,
	input  wire  expired_i,
	output logic draw_o,
	output logic timer_clear_o,
	output logic timer_run_o
);

	particle_pkg::draw_state_e state_q;
	particle_pkg::draw_state_e state_d;

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Clear the wait counter, one cycle
			particle_pkg::ST_INIT: state_d = particle_pkg::ST_DRAW;
			// Single pixel per frame
			particle_pkg::ST_DRAW: state_d = particle_pkg::ST_WAIT;
			// Hold until the timer runs out
			particle_pkg::ST_WAIT: begin
				if (expired_i) begin
					state_d = particle_pkg::ST_INIT;
				end
			end
			default: state_d = particle_pkg::ST_INIT;
		endcase
	end

	// ======================================================================
	// State and output registers
	// ======================================================================

	// Outputs are decoded from the next state, so they line up
	// with the state register but stay low through reset
	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			state_q       <= particle_pkg::ST_INIT;
			draw_o        <= 1'b0;
			timer_clear_o <= 1'b0;
			timer_run_o   <= 1'b0;
		end else begin
			state_q       <= state_d;
			draw_o        <= (state_d == particle_pkg::ST_DRAW);
			timer_clear_o <= (state_d == particle_pkg::ST_INIT);
			timer_run_o   <= (state_d == particle_pkg::ST_WAIT);
		end
	end

endmodule

`default_nettype wire

/* hdl/frame_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_timer #(
	parameter logic [31:0] WAIT_CYCLES = 32'd1000000
) (
	input  wire  CLOCK_50,
	input  wire  reset,
	input  wire  clear_i,
	input  wire  run_i,
	output logic expired_o
);

	// Cycles spent in the wait state this frame
	logic [31:0] count_q;

	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			count_q <= 32'd0;
		end else if (clear_i) begin
			// Restart at the top of each frame
			count_q <= 32'd0;
		end else if (run_i) begin
			count_q <= count_q + 32'd1;
		end
	end

	// Strictly greater, so the wait lasts WAIT_CYCLES+2 cycles
	assign expired_o = (count_q > WAIT_CYCLES);

endmodule

`default_nettype wire

/* hdl/particle_draw_top.sv */
`timescale 1ns/1ns
`default_nettype none

module particle_draw_top #(
	parameter particle_pkg::coord_t BOX_SIZE    = 10'd200,
	parameter logic [31:0]          WAIT_CYCLES = 32'd1000000,
	parameter particle_pkg::color_t PIXEL_COLOR = 8'hff
) (
	input  wire                        CLOCK_50,
	input  wire                        reset,
	output logic                       fb_we_o,
	output particle_pkg::pixel_write_t fb_wr_o
);

	// ======================================================================
	// Control
	// ======================================================================

	logic draw;
	logic timer_clear;
	logic timer_run;
	logic timer_expired;

	draw_fsm u_draw_fsm (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.expired_i     (timer_expired),
		.draw_o        (draw),
		.timer_clear_o (timer_clear),
		.timer_run_o   (timer_run)
	);

	// Per-frame throttle
	frame_timer #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) u_frame_timer (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.clear_i   (timer_clear),
		.run_i     (timer_run),
		.expired_o (timer_expired)
	);

	// ======================================================================
	// Data path
	// ======================================================================

	particle_pkg::particle_t particle;

	particle_state #(
		.BOX_SIZE (BOX_SIZE)
	) u_particle_state (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.draw_i     (draw),
		.particle_o (particle)
	);

	// Frame buffer never pushes back
	pixel_writer #(
		.PIXEL_COLOR (PIXEL_COLOR)
	) u_pixel_writer (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.draw_i     (draw),
		.particle_i (particle),
		.fb_we_o    (fb_we_o),
		.fb_wr_o    (fb_wr_o)
	);

endmodule

`default_nettype wire

/* hdl/particle_pkg.sv */
`default_nettype none

package particle_pkg;

	// ======================================================================
	// Widths that carry a meaning
	// ======================================================================

	// Screen coordinate, unsigned pixel column or row
	typedef logic [9:0] coord_t;
	// Velocity component, two's complement
	typedef logic signed [9:0] vel_t;
	// Linear pixel index, covers 640 x 480
	typedef logic [18:0] fb_addr_t;
	// 8-bit colour as stored in the VGA buffer
	typedef logic [7:0] color_t;

	// Frame sequence
	typedef enum logic [1:0] {
		ST_INIT,
		ST_DRAW,
		ST_WAIT
	} draw_state_e;

	// Position and velocity of the particle
	typedef struct packed {
		coord_t x;
		coord_t y;
		vel_t   vx;
		vel_t   vy;
	} particle_t;

	// One frame-buffer write
	typedef struct packed {
		fb_addr_t addr;
		color_t   color;
	} pixel_write_t;

	// Line pitch of the frame buffer
	localparam fb_addr_t SCREEN_WIDTH = 19'd640;

	// Reset position and velocity
	localparam coord_t START_X = 10'd30;
	localparam coord_t START_Y = 10'd30;
	localparam vel_t   START_V = 10'sd1;

endpackage

`default_nettype wire

/* hdl/particle_state.sv */
`timescale 1ns/1ns
`default_nettype none

module particle_state #(
	parameter particle_pkg::coord_t BOX_SIZE = 10'd200
) (
	input  wire                     CLOCK_50,
	input  wire                     reset,
	input  wire                     draw_i,
	output particle_pkg::particle_t particle_o
);

	particle_pkg::particle_t cur_q;
	particle_pkg::particle_t nxt;

	// ======================================================================
	// Wall bounce for one axis
	// ======================================================================

	// Reverse at the far wall, or when the next step would land
	// on or below zero
	function automatic particle_pkg::vel_t bounce_vel(
		input particle_pkg::coord_t pos,
		input particle_pkg::vel_t   vel
	);
		logic signed [10:0] probe;
		begin
			// One extra bit so the sum never wraps
			probe = $signed({1'b0, pos}) + $signed({vel[9], vel});
			if ((pos > BOX_SIZE) || (probe <= 11'sd0)) begin
				return -vel;
			end
			return vel;
		end
	endfunction

	// New velocity first, then step with it
	always_comb begin
		nxt.vx = bounce_vel(cur_q.x, cur_q.vx);
		nxt.vy = bounce_vel(cur_q.y, cur_q.vy);
		nxt.x  = cur_q.x + particle_pkg::coord_t'(nxt.vx);
		nxt.y  = cur_q.y + particle_pkg::coord_t'(nxt.vy);
	end

	// ======================================================================
	// Particle register
	// ======================================================================

	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			cur_q.x  <= particle_pkg::START_X;
			cur_q.y  <= particle_pkg::START_Y;
			cur_q.vx <= particle_pkg::START_V;
			cur_q.vy <= particle_pkg::START_V;
		end else if (draw_i) begin
			// One step per frame
			cur_q <= nxt;
		end
	end

	assign particle_o = cur_q;

endmodule

`default_nettype wire

/* hdl/pixel_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_writer #(
	parameter particle_pkg::color_t PIXEL_COLOR = 8'hff
) (
	input  wire                        CLOCK_50,
	input  wire                        reset,
	input  wire                        draw_i,
	input  particle_pkg::particle_t    particle_i,
	output logic                       fb_we_o,
	output particle_pkg::pixel_write_t fb_wr_o
);

	// Row-major index, y * 640 + x
	particle_pkg::fb_addr_t pix_addr;

	assign pix_addr = particle_pkg::fb_addr_t'(particle_i.y) * particle_pkg::SCREEN_WIDTH
		+ particle_pkg::fb_addr_t'(particle_i.x);

	// Write strobe, one cycle per drawn pixel
	always_ff @(posedge CLOCK_50) begin
		if (!reset) begin
			fb_we_o <= 1'b0;
		end else begin
			fb_we_o <= draw_i;
		end
	end

	// Address and colour, captured from the pre-update position
	always_ff @(posedge CLOCK_50) begin
		if (draw_i) begin
			fb_wr_o.addr  <= pix_addr;
			fb_wr_o.color <= PIXEL_COLOR;
		end
	end

endmodule

`default_nettype wire

/* src.f */
hdl/particle_pkg.sv
hdl/draw_fsm.sv
hdl/frame_timer.sv
hdl/particle_state.sv
hdl/pixel_writer.sv
hdl/particle_draw_top.sv
verif/particle_draw_props.sv
verif/particle_draw_tb.sv

/* verif/particle_draw_props.sv */
`timescale 1ns/1ns
`default_nettype none

module particle_draw_props #(
	parameter bit CHECK_ORDER = 1'b1
) (
	input wire                       CLOCK_50,
	input wire                       reset,
	input wire                       strobe_i,
	input particle_pkg::draw_state_e state_i
);

	// Single-cycle pulse per frame
	a_strobe_single: assert property (@(posedge CLOCK_50) disable iff (!reset)
		strobe_i |=> !strobe_i)
		else $error("strobe high on two consecutive cycles");

	// ======================================================================
	// Frame sequence INIT, DRAW, WAIT
	// ======================================================================

	a_init_to_draw: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(CHECK_ORDER && state_i == particle_pkg::ST_INIT)
		|=> (state_i == particle_pkg::ST_DRAW))
		else $error("state left ST_INIT for something other than ST_DRAW");

	a_draw_to_wait: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(CHECK_ORDER && state_i == particle_pkg::ST_DRAW)
		|=> (state_i == particle_pkg::ST_WAIT))
		else $error("state left ST_DRAW for something other than ST_WAIT");

	// Wait holds, or starts the next frame
	a_wait_exit: assert property (@(posedge CLOCK_50) disable iff (!reset)
		(CHECK_ORDER && state_i == particle_pkg::ST_WAIT)
		|=> (state_i == particle_pkg::ST_WAIT || state_i == particle_pkg::ST_INIT))
		else $error("state left ST_WAIT for something other than ST_INIT");

endmodule

// Controller state and its draw pulse
bind draw_fsm particle_draw_props #(.CHECK_ORDER(1'b1)) u_fsm_props (
	.CLOCK_50 (CLOCK_50),
	.reset    (reset),
	.strobe_i (draw_o),
	.state_i  (state_q)
);

// Frame-buffer write strobe only
bind pixel_writer particle_draw_props #(.CHECK_ORDER(1'b0)) u_we_props (
	.CLOCK_50 (CLOCK_50),
	.reset    (reset),
	.strobe_i (fb_we_o),
	.state_i  (particle_pkg::ST_INIT)
);

`default_nettype wire

/* verif/particle_draw_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module particle_draw_tb;

	localparam particle_pkg::coord_t BOX   = 10'd40;
	localparam logic [31:0]          WAIT  = 32'd8;
	localparam particle_pkg::color_t COLOR = 8'he3;
	// Strobe to strobe spacing in clock cycles
	localparam int FRAME        = int'(WAIT) + 4;
	localparam int RESET_CYCLES = 8;
	localparam int LINE_PITCH   = 640;
	localparam int FIRST_ADDR   = 30 * LINE_PITCH + 30;
	localparam int WATCHDOG_NS  = (600 * FRAME + 2 * RESET_CYCLES) * 10;

	logic CLOCK_50 = 1'b0;
	logic reset = 1'b0;
	logic fb_we;
	particle_pkg::pixel_write_t fb_wr;

	// Scoreboard state owned by the compare process
	particle_pkg::particle_t model_q;
	int errors = 0;
	int addr_errs = 0;
	int color_errs = 0;
	int gap_errs = 0;
	int width_errs = 0;
	int tests_failed = 0;
	int strobes = 0;
	int cyc_abs = 0;
	int since_rst = 0;
	int last_cyc = 0;
	int first_addr = 0;
	int first_cyc = 0;
	particle_pkg::color_t first_color = 8'h00;
	bit have_last = 1'b0;
	bit prev_we = 1'b0;

	particle_draw_top #(
		.BOX_SIZE    (BOX),
		.WAIT_CYCLES (WAIT),
		.PIXEL_COLOR (COLOR)
	) dut (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.fb_we_o  (fb_we),
		.fb_wr_o  (fb_wr)
	);

	initial begin
		forever #5 CLOCK_50 = ~CLOCK_50;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// Pixel of the current position
	// nxt gets the particle one frame on
	function automatic particle_pkg::pixel_write_t model_frame(
		input  particle_pkg::particle_t cur,
		output particle_pkg::particle_t nxt
	);
		int x;
		int y;
		int vx;
		int vy;
		particle_pkg::pixel_write_t pw;
		begin
			x = int'(cur.x);
			y = int'(cur.y);
			vx = int'($signed(cur.vx));
			vy = int'($signed(cur.vy));
			pw.addr = particle_pkg::fb_addr_t'(y * LINE_PITCH + x);
			pw.color = COLOR;
			// Flip past the far wall or when the step lands at zero or below
			if (x > int'(BOX) || x + vx <= 0) begin
				vx = -vx;
			end
			if (y > int'(BOX) || y + vy <= 0) begin
				vy = -vy;
			end
			nxt.x = particle_pkg::coord_t'(x + vx);
			nxt.y = particle_pkg::coord_t'(y + vy);
			nxt.vx = particle_pkg::vel_t'(vx);
			nxt.vy = particle_pkg::vel_t'(vy);
			return pw;
		end
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		begin
			s = s ^ (s << 13);
			s = s ^ (s >> 17);
			s = s ^ (s << 5);
			return s;
		end
	endfunction

	// Address, colour, spacing and width of one strobe
	task automatic check_strobe();
		particle_pkg::particle_t nxt;
		particle_pkg::pixel_write_t exp;
		begin
			exp = model_frame(model_q, nxt);
			model_q = nxt;
			if (fb_wr.addr !== exp.addr) begin
				$display("ERR t=%0t fb_wr_o.addr expected %0d actual %0d",
					$time, exp.addr, fb_wr.addr);
				addr_errs++;
				errors++;
			end
			if (fb_wr.color !== exp.color) begin
				$display("ERR t=%0t fb_wr_o.color expected %0h actual %0h",
					$time, exp.color, fb_wr.color);
				color_errs++;
				errors++;
			end
			if (prev_we) begin
				$display("fb_we_o stayed high for a second cycle at t=%0t", $time);
				width_errs++;
				errors++;
			end
			if (have_last && (cyc_abs - last_cyc != FRAME)) begin
				$display("ERR t=%0t fb_we_o period expected %0d actual %0d",
					$time, FRAME, cyc_abs - last_cyc);
				gap_errs++;
				errors++;
			end
			if (strobes == 0) begin
				first_addr = int'(fb_wr.addr);
				first_color = fb_wr.color;
				first_cyc = since_rst;
			end
			strobes++;
			have_last = 1'b1;
			last_cyc = cyc_abs;
		end
	endtask

	// Compare process sampling on the rising edge
	always @(posedge CLOCK_50) begin
		cyc_abs = cyc_abs + 1;
		if (reset === 1'b1) begin
			since_rst = since_rst + 1;
		end
		if (fb_we === 1'b1) begin
			check_strobe();
		end
		if (reset !== 1'b1) begin
			model_q.x = particle_pkg::START_X;
			model_q.y = particle_pkg::START_Y;
			model_q.vx = particle_pkg::START_V;
			model_q.vy = particle_pkg::START_V;
			strobes = 0;
			since_rst = 0;
			have_last = 1'b0;
			prev_we = 1'b0;
		end else begin
			prev_we = fb_we;
		end
	end

	// ======================================================================
	// Sequence
	// ======================================================================

	task automatic expect_we_low();
		begin
			if (fb_we !== 1'b0) begin
				$display("ERR t=%0t fb_we_o expected 0 actual %b", $time, fb_we);
				errors++;
			end
		end
	endtask

	// Strobe stays low through reset and on the two edges after release
	task automatic hold_reset(input int cycles);
		begin
			reset = 1'b0;
			repeat (cycles) begin
				@(negedge CLOCK_50);
				expect_we_low();
			end
			reset = 1'b1;
			// Value seen by the second edge after release
			@(negedge CLOCK_50);
			expect_we_low();
		end
	endtask

	task automatic report_test(input string name, input int errs);
		begin
			if (errs == 0) begin
				$display("%s: ok", name);
			end else begin
				$display("%s: %0d error(s)", name, errs);
				tests_failed++;
			end
		end
	endtask

	// First strobe after reset lands on the third edge at the start position
	task automatic check_first(output int errs);
		begin
			errs = 0;
			if (first_addr != FIRST_ADDR) begin
				$display("ERR t=%0t fb_wr_o.addr expected %0d actual %0d",
					$time, FIRST_ADDR, first_addr);
				errs++;
			end
			if (first_color !== COLOR) begin
				$display("ERR t=%0t fb_wr_o.color expected %0h actual %0h",
					$time, COLOR, first_color);
				errs++;
			end
			if (first_cyc != 3) begin
				$display("First strobe came on edge %0d after reset, not edge 3", first_cyc);
				errs++;
			end
			errors += errs;
		end
	endtask

	initial begin
		int e0;
		int errs;
		logic [31:0] rnd;
		int delay;
		e0 = errors;
		hold_reset(RESET_CYCLES);
		report_test("1 reset", errors - e0);
		while (strobes < 1) begin
			@(negedge CLOCK_50);
		end
		check_first(errs);
		report_test("2 first pixel", errs);
		while (strobes < 200) begin
			@(negedge CLOCK_50);
		end
		report_test("3 bounce trajectory", addr_errs + color_errs);
		report_test("4 frame period", gap_errs);
		report_test("5 strobe width", width_errs);
		// Reapply reset at a pseudo-random point in a frame
		rnd = xorshift32(32'h96d4);
		delay = 20 + int'(rnd % 32'd37);
		repeat (delay) begin
			@(negedge CLOCK_50);
		end
		e0 = errors;
		hold_reset(RESET_CYCLES);
		while (strobes < 100) begin
			@(negedge CLOCK_50);
		end
		check_first(errs);
		report_test("6 mid-run reset", errors - e0);
		$display("Tests run 6, failed %0d, errors %0d", tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog covering 600 frames plus both resets
	initial begin
		#(WATCHDOG_NS);
		$display("Run did not finish within %0d ns, strobes stopped coming", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
